/* Makefile */
.PHONY: sim clean

# build with assertions on, then run and look for the pass line in the log
sim:
	verilator --binary --timing --assert -j 0 --top-module tbSnnConv -f snnConvTop.f
	./obj_dir/VtbSnnConv | tee sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* filterBank.sv */
`timescale 1ns/1ps
`include "snnConv_params.svh"

module filterBank (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             filterWrValid,
    input  snnConvPkg::filterWrT             filterWr,
    output logic [`WIN_DIM*`DATA_WIDTH-1:0]  weights
);
    import snnConvPkg::*;

    filterRowT rows [`WIN_DIM];      // stored weight rows
    filterRowT nextRows [`WIN_DIM];  // rows after this cycle's write

    // write-first view of the bank
    always_comb begin
        for (int r = 0; r < `WIN_DIM; r++) begin
            if (filterWrValid && filterWr.rowIdx == 3'(r)) begin
                nextRows[r] = filterWr.weights;
            end else begin
                nextRows[r] = rows[r];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int r = 0; r < `WIN_DIM; r++) begin
                rows[r] <= '0;   // all weights zero out of reset
            end
        end else begin
            for (int r = 0; r < `WIN_DIM; r++) begin
                rows[r] <= nextRows[r];
            end
        end
    end

    // row 0 in the top 40 bits
    always_comb begin
        for (int r = 0; r < `WIN_DIM; r++) begin
            weights[(`WIN_DIM-1-r)*`DATA_WIDTH +: `DATA_WIDTH] = nextRows[r];
        end
    end

    // the splitter must have filtered out codes 0, 6 and 7
    rowIdxInRange: assert property (
        @(posedge clk) disable iff (!rstN)
        filterWrValid |-> (filterWr.rowIdx < 3'(`WIN_DIM))
    ) else $error("filterBank write to row %0d", filterWr.rowIdx);

endmodule

/* packetSplit.sv */
`timescale 1ns/1ps
`include "snnConv_params.svh"

module packetSplit (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 pktValid,
    input  snnConvPkg::packetT   pkt,
    output logic                 filterWrValid,
    output snnConvPkg::filterWrT filterWr,
    output logic                 jobValid,
    output snnConvPkg::convJobT  job,
    output logic                 rowError
);
    import snnConvPkg::*;

    logic isFilter;
    logic rowOk;
    logic takeFilter;
    logic takeJob;

    assign isFilter = pkt.ifmapbFilter;

    // only codes 1 to 5 address a weight row
    always_comb begin
        case (pkt.filterRow)
            3'd1, 3'd2, 3'd3, 3'd4, 3'd5: rowOk = 1'b1;
            default:                       rowOk = 1'b0;
        endcase
    end

    assign takeFilter = pktValid && isFilter && rowOk;
    assign takeJob    = pktValid && !isFilter;

    // strobes one cycle after the packet edge
    always_ff @(posedge clk) begin
        if (!rstN) begin
            filterWrValid <= 1'b0;
            jobValid      <= 1'b0;
            rowError      <= 1'b0;
        end else begin
            filterWrValid <= takeFilter;
            jobValid      <= takeJob;
            rowError      <= pktValid && isFilter && !rowOk;  // bad row is dropped
        end
    end

    // filter row write payload
    always_ff @(posedge clk) begin
        if (takeFilter) begin
            filterWr.rowIdx  <= pkt.filterRow - 3'd1;
            filterWr.weights <= pkt.data;
        end
    end

    // ifmap job fields
    always_ff @(posedge clk) begin
        if (takeJob) begin
            job.spikes  <= pkt.data[`DATA_WIDTH-1 -: `WIN_DIM*`WIN_DIM];
            job.convLoc <= pkt.data[(`DATA_WIDTH-`WIN_DIM*`WIN_DIM-1):2];
            job.size    <= pkt.data[1:0];
        end
    end

    // a packet goes to exactly one place so the three strobes never overlap
    onlyOneStrobe: assert property (
        @(posedge clk) disable iff (!rstN)
        $onehot0({filterWrValid, jobValid, rowError})
    ) else $error("packetSplit raised more than one output strobe");

endmodule

/* snnConvPkg.sv */
`include "snnConv_params.svh"

package snnConvPkg;

    typedef logic signed [`FILTER_WIDTH-1:0] weightT;

    // weight c sits at bits 39-8c down to 32-8c
    typedef logic [`DATA_WIDTH-1:0] filterRowT;

    // spike at row r, col c is bit 24-(5r+c)
    typedef logic [`WIN_DIM*`WIN_DIM-1:0] spikeWinT;

    // whatever is left of the data word after the window and the size code
    typedef logic [`DATA_WIDTH-`WIN_DIM*`WIN_DIM-3:0] convLocT;

    typedef logic [1:0] sizeCodeT;  // 0 -> 3x3, 1 -> 4x4, 2/3 -> 5x5
    typedef logic [2:0] rowCodeT;   // 1..5 select rows 0..4
    typedef logic signed [`SUM_WIDTH-1:0] psumT;

    typedef struct packed {
        logic [`DATA_WIDTH-1:0] data;
        logic                   ifmapbFilter;  // 0 ifmap, 1 filter
        rowCodeT                filterRow;
    } packetT;

    typedef struct packed {
        logic [2:0] rowIdx;   // 0 to 4
        filterRowT  weights;
    } filterWrT;

    typedef struct packed {
        spikeWinT spikes;
        convLocT  convLoc;
        sizeCodeT size;
    } convJobT;

    typedef struct packed {
        psumT    psum;
        convLocT convLoc;
    } resultT;

endpackage

/* snnConvTop.f */
+incdir+.
snnConvPkg.sv
packetSplit.sv
filterBank.sv
spikeConvMac.sv
snnConvTop.sv
tbSnnConv.sv

/* snnConvTop.sv */
`timescale 1ns/1ps
`include "snnConv_params.svh"

module snnConvTop (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 pktValid,
    input  snnConvPkg::packetT   pkt,
    output logic                 resValid,
    output snnConvPkg::resultT   res,
    output logic                 rowError
);
    import snnConvPkg::*;

    logic                            filterWrValid;
    filterWrT                        filterWr;
    logic                            jobValid;
    convJobT                         job;
    logic [`WIN_DIM*`DATA_WIDTH-1:0] weights;   // five rows, row 0 on top

    // packet front end
    packetSplit i_packetSplit (
        .clk           (clk),
        .rstN          (rstN),
        .pktValid      (pktValid),
        .pkt           (pkt),
        .filterWrValid (filterWrValid),
        .filterWr      (filterWr),
        .jobValid      (jobValid),
        .job           (job),
        .rowError      (rowError)
    );

    filterBank i_filterBank (
        .clk           (clk),
        .rstN          (rstN),
        .filterWrValid (filterWrValid),
        .filterWr      (filterWr),
        .weights       (weights)
    );

    // two stages behind the splitter
    spikeConvMac i_spikeConvMac (
        .clk      (clk),
        .rstN     (rstN),
        .jobValid (jobValid),
        .job      (job),
        .weights  (weights),
        .resValid (resValid),
        .res      (res)
    );

endmodule

/* snnConv_params.svh */
`ifndef SNN_CONV_PARAMS_SVH
`define SNN_CONV_PARAMS_SVH

// bits per signed weight
`define FILTER_WIDTH 8

// rows and columns of the spike window and of the filter
`define WIN_DIM 5

// packet data word, one filter row or one ifmap job
`define DATA_WIDTH 40

// signed accumulator result
`define SUM_WIDTH 16

`endif

/* spikeConvMac.sv */
`timescale 1ns/1ps
`include "snnConv_params.svh"

module spikeConvMac (
    input  logic                             clk,
    input  logic                             rstN,
    input  logic                             jobValid,
    input  snnConvPkg::convJobT              job,
    input  logic [`WIN_DIM*`DATA_WIDTH-1:0]  weights,
    output logic                             resValid,
    output snnConvPkg::resultT               res
);
    import snnConvPkg::*;

    logic [`WIN_DIM-1:0] kMask;          // bit i set when row/col i is inside k
    psumT                rowSum [`WIN_DIM];
    psumT                rowSumQ [`WIN_DIM];
    convLocT             locQ;
    logic                validQ;
    psumT                total;

    // weight at row r, col c of the packed bank
    function automatic weightT weightAt(
        input logic [`WIN_DIM*`DATA_WIDTH-1:0] bank,
        input int                               r,
        input int                               c
    );
        weightAt = weightT'(
            bank[(`WIN_DIM-1-r)*`DATA_WIDTH + (`WIN_DIM-1-c)*`FILTER_WIDTH +: `FILTER_WIDTH]
        );
    endfunction

    // size code picks the top-left k-by-k corner
    always_comb begin
        case (job.size)
            2'd0:    kMask = 5'b00111;  // 3x3
            2'd1:    kMask = 5'b01111;  // 4x4
            default: kMask = 5'b11111;  // 2 and 3 both mean 5x5
        endcase
    end

    // masked spike-weighted sum per row
    always_comb begin
        for (int r = 0; r < `WIN_DIM; r++) begin
            rowSum[r] = '0;
            for (int c = 0; c < `WIN_DIM; c++) begin
                if (kMask[r] && kMask[c]
                        && job.spikes[(`WIN_DIM*`WIN_DIM-1) - (`WIN_DIM*r + c)]) begin
                    rowSum[r] = rowSum[r] + psumT'(weightAt(weights, r, c));  // sign extend
                end
            end
        end
    end

    // stage 1
    always_ff @(posedge clk) begin
        if (!rstN) begin
            validQ <= 1'b0;
        end else begin
            validQ <= jobValid;
        end
    end

    always_ff @(posedge clk) begin
        if (jobValid) begin
            for (int r = 0; r < `WIN_DIM; r++) begin
                rowSumQ[r] <= rowSum[r];
            end
            locQ <= job.convLoc;
        end
    end

    // fold the row sums
    always_comb begin
        total = '0;
        for (int r = 0; r < `WIN_DIM; r++) begin
            total = total + rowSumQ[r];
        end
    end

    // stage 2
    always_ff @(posedge clk) begin
        if (!rstN) begin
            resValid <= 1'b0;
        end else begin
            resValid <= validQ;
        end
    end

    always_ff @(posedge clk) begin
        if (validQ) begin
            res.psum    <= total;
            res.convLoc <= locQ;   // tag rides along unchanged
        end
    end

    // fixed two-stage latency, no bubbles and no drops
    fixedLatency: assert property (
        @(posedge clk) disable iff (!rstN)
        resValid == $past(jobValid, 2)
    ) else $error("spikeConvMac resValid out of step with jobValid");

endmodule

/* tbSnnConv.sv */
`timescale 1ns/1ps
`include "snnConv_params.svh"

module tbSnnConv;
    import snnConvPkg::*;

    typedef enum logic [1:0] {KIND_NONE, KIND_RES, KIND_ERR} kindT;

    typedef struct packed {
        logic                   active;      // 0 is an idle cycle
        logic                   isFilter;
        rowCodeT                rowCode;
        logic                   randSpikes;  // replace the window with random bits
        logic [`DATA_WIDTH-1:0] data;
        kindT                   kind;        // what the DUT should answer
    } stimT;

    typedef struct {
        int      due;
        psumT    psum;
        convLocT loc;
    } expResT;

    logic    clk = 1'b0;
    logic    rstN;
    logic    pktValid;
    packetT  pkt;
    logic    resValid;
    resultT  res;
    logic    rowError;

    int        cycleCount = 0;
    stimT      stim[$];
    expResT    resQ[$];
    int        errQ[$];
    filterRowT modelRow [`WIN_DIM];

    snnConvTop i_snnConvTop (
        .clk      (clk),
        .rstN     (rstN),
        .pktValid (pktValid),
        .pkt      (pkt),
        .resValid (resValid),
        .res      (res),
        .rowError (rowError)
    );

    always #50 clk = ~clk;

    always @(posedge clk) cycleCount <= cycleCount + 1;  // read on the falling edge

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    function automatic filterRowT packRow(input int w0, input int w1, input int w2,
                                          input int w3, input int w4);
        packRow = {weightT'(w0), weightT'(w1), weightT'(w2), weightT'(w3), weightT'(w4)};
    endfunction

    function automatic stimT filterEntry(input rowCodeT code, input filterRowT w,
                                         input kindT kind);
        filterEntry = '0;
        filterEntry.active = 1'b1;
        filterEntry.isFilter = 1'b1;
        filterEntry.rowCode = code;
        filterEntry.data = w;
        filterEntry.kind = kind;
    endfunction

    function automatic stimT ifmapEntry(input spikeWinT s, input convLocT loc,
                                        input sizeCodeT sz, input logic rnd);
        ifmapEntry = '0;
        ifmapEntry.active = 1'b1;
        ifmapEntry.randSpikes = rnd;
        ifmapEntry.data = {s, loc, sz};  // window, tag, size code
        ifmapEntry.kind = KIND_RES;
    endfunction

    // sum of weights under set spikes in the top-left k-by-k corner
    function automatic psumT modelPsum(input spikeWinT s, input sizeCodeT sz);
        int     k;
        int     acc;
        weightT w;
        k = (sz == 2'd0) ? 3 : ((sz == 2'd1) ? 4 : 5);
        acc = 0;
        for (int r = 0; r < k; r++) begin
            for (int c = 0; c < k; c++) begin
                if (s[24 - (5 * r + c)]) begin
                    w = weightT'(modelRow[r][39 - 8 * c -: 8]);
                    acc = acc + int'(w);
                end
            end
        end
        modelPsum = psumT'(acc);
    endfunction

    task automatic buildTable();
        spikeWinT mixed;
        mixed = 25'b10110_01101_11011_00111_10101;
        stim.push_back(ifmapEntry(25'h1FFFFFF, 13'h0011, 2'd2, 1'b0));  // weights still zero
        stim.push_back('0);
        stim.push_back('0);
        stim.push_back(filterEntry(3'd1, packRow(1, -2, 3, -4, 5), KIND_NONE));
        stim.push_back(filterEntry(3'd2, packRow(-6, 7, -8, 9, -10), KIND_NONE));
        stim.push_back(filterEntry(3'd3, packRow(11, -12, 13, -14, 15), KIND_NONE));
        stim.push_back(filterEntry(3'd4, packRow(20, -30, 40, -50, 60), KIND_NONE));
        stim.push_back(filterEntry(3'd5, packRow(-100, 127, -128, 64, -1), KIND_NONE));
        stim.push_back('0);
        stim.push_back(ifmapEntry(25'h1FFFFFF, 13'h1ABC, 2'd2, 1'b0));
        // same window with every size code
        stim.push_back(ifmapEntry(mixed, 13'h0100, 2'd0, 1'b0));
        stim.push_back(ifmapEntry(mixed, 13'h0101, 2'd1, 1'b0));
        stim.push_back(ifmapEntry(mixed, 13'h0102, 2'd2, 1'b0));
        stim.push_back(ifmapEntry(mixed, 13'h0103, 2'd3, 1'b0));
        // bad row codes leave the weights alone
        stim.push_back(filterEntry(3'd0, packRow(9, 9, 9, 9, 9), KIND_ERR));
        stim.push_back(ifmapEntry(mixed, 13'h0200, 2'd2, 1'b0));
        stim.push_back(filterEntry(3'd6, packRow(-9, -9, -9, -9, -9), KIND_ERR));
        stim.push_back(filterEntry(3'd7, packRow(77, 77, 77, 77, 77), KIND_ERR));
        stim.push_back(ifmapEntry(mixed, 13'h0201, 2'd3, 1'b0));
        stim.push_back('0);
        for (int i = 0; i < 8; i++) begin
            stim.push_back(ifmapEntry('0, convLocT'(13'h0400 + i), sizeCodeT'(i), 1'b1));
        end
        // rewrite then read on the very next cycle
        stim.push_back(filterEntry(3'd3, packRow(-1, 2, -3, 4, -5), KIND_NONE));
        stim.push_back(ifmapEntry(25'h1FFFFFF, 13'h0800, 2'd2, 1'b0));
        stim.push_back(filterEntry(3'd1, packRow(50, 50, -50, -50, 0), KIND_NONE));
        stim.push_back(ifmapEntry(mixed, 13'h0801, 2'd0, 1'b0));
    endtask

    // drive one table entry and queue what it should produce
    task automatic applyEntry(input stimT e);
        expResT x;
        pktValid = e.active;
        pkt.ifmapbFilter = e.isFilter;
        pkt.filterRow = e.rowCode;
        pkt.data = e.data;
        if (e.active && e.randSpikes) begin
            pkt.data[39:15] = spikeWinT'($urandom);
        end
        case (e.kind)
            KIND_RES: begin
                x.due = cycleCount + 3;
                x.psum = modelPsum(pkt.data[39:15], pkt.data[1:0]);
                x.loc = pkt.data[14:2];
                resQ.push_back(x);
            end
            KIND_ERR: errQ.push_back(cycleCount + 1);
            default: begin
                if (e.active && e.isFilter) begin
                    modelRow[int'(e.rowCode) - 1] = e.data;
                end
            end
        endcase
    endtask

    task automatic checkResult();
        expResT e;
        if (resValid) begin
            assert (resQ.size() != 0)
                else abortRun($sformatf("ERROR t=%0t resValid expected 0 got 1", $time));
            if (resQ.size() != 0) begin
                e = resQ.pop_front();
                assert (e.due == cycleCount)
                    else abortRun($sformatf("ERROR t=%0t resValid cycle expected %0d got %0d",
                                            $time, e.due, cycleCount));
                assert (res.psum == e.psum)
                    else abortRun($sformatf("ERROR t=%0t res.psum expected %0d got %0d",
                                            $time, e.psum, res.psum));
                assert (res.convLoc == e.loc)
                    else abortRun($sformatf("ERROR t=%0t res.convLoc expected %h got %h",
                                            $time, e.loc, res.convLoc));
            end
        end else if (resQ.size() != 0) begin
            assert (resQ[0].due > cycleCount)
                else abortRun($sformatf("ERROR t=%0t resValid expected 1 got 0", $time));
        end
    endtask

    task automatic checkRowError();
        if (rowError) begin
            assert (errQ.size() != 0 && errQ[0] == cycleCount)
                else abortRun($sformatf("ERROR t=%0t rowError expected 0 got 1", $time));
            void'(errQ.pop_front());
        end else if (errQ.size() != 0) begin
            assert (errQ[0] > cycleCount)
                else abortRun($sformatf("ERROR t=%0t rowError expected 1 got 0", $time));
        end
    endtask

    // outputs settle after the rising edge and are sampled on the falling one
    always @(negedge clk) begin
        if (rstN) begin
            checkResult();
            checkRowError();
        end
    end

    initial begin
        int waited;
        rstN = 1'b0;
        pktValid = 1'b0;
        pkt = '0;
        void'($urandom(4));
        for (int r = 0; r < `WIN_DIM; r++) begin
            modelRow[r] = '0;
        end
        buildTable();
        repeat (3) @(negedge clk);
        rstN = 1'b1;
        repeat (5) @(negedge clk);  // idle cycles with nothing expected
        foreach (stim[i]) begin
            applyEntry(stim[i]);
            @(negedge clk);
        end
        pktValid = 1'b0;
        waited = 0;
        while ((resQ.size() != 0 || errQ.size() != 0) && waited < 20) begin
            @(posedge clk);
            waited++;
        end
        repeat (4) @(posedge clk);
        if (resQ.size() == 0 && errQ.size() == 0) begin
            $display("All checks passed");
            $finish;
        end else begin
            abortRun("timed out waiting for outstanding results or rowError strobes");
        end
    end

endmodule
